// File: filelist.f
rtl/dispatch_pkg.sv
rtl/inst_decoder.sv
rtl/map_table.sv
rtl/free_list.sv
rtl/rob_tracker.sv
rtl/dispatch_ctrl.sv
rtl/rename_dispatch.sv
verif/tb_rename_dispatch.sv

// File: Bender.yml
package:
  name: rename_dispatch

sources:
  - rtl/dispatch_pkg.sv
  - rtl/inst_decoder.sv
  - rtl/map_table.sv
  - rtl/free_list.sv
  - rtl/rob_tracker.sv
  - rtl/dispatch_ctrl.sv
  - rtl/rename_dispatch.sv
  - target: test
    files:
      - verif/tb_rename_dispatch.sv

// File: verif/tb_rename_dispatch.sv
`timescale 1ns/1ns
module tb_rename_dispatch;

	typedef logic [dispatch_pkg::PR_W-1:0] tag_t;

	localparam int NUM_INST    = 500;
	localparam int CYCLE_LIMIT = NUM_INST * 8 + 200;

	logic clock;
	logic rst_n;
	logic inst_valid;
	logic [31:0] inst;
	logic [31:0] pc;
	logic rs_stall;
	logic cdb_valid;
	tag_t cdb_pr;
	logic retire_valid;
	tag_t retire_old_pr;

	logic stall, disp_valid, src1_ready, src2_ready, disp_halt, illegal, halted;
	dispatch_pkg::fu_sel_t  fu_sel;
	dispatch_pkg::op_sel_t  op_sel;
	dispatch_pkg::opa_sel_t opa_sel;
	dispatch_pkg::opb_sel_t opb_sel;
	tag_t dest_pr, old_pr, src1_pr, src2_pr;
	logic [dispatch_pkg::ROB_W-1:0] rob_index;
	logic [31:0] disp_pc;

	// expected decode of the instruction sitting at fetch
	dispatch_pkg::fu_sel_t  e_fu;
	dispatch_pkg::opa_sel_t e_opa;
	dispatch_pkg::opb_sel_t e_opb;
	logic [3:0] e_op;
	logic [4:0] e_dest, e_r1, e_r2;
	logic e_halt, e_ill;

	// reference model state
	tag_t m_map [32];
	logic m_rdy [32];
	tag_t fl_q[$];
	tag_t pend_q[$]; // renamed tags still waiting for writeback
	tag_t rob_dest_q[$];
	tag_t rob_old_q[$];
	tag_t held_q[$]; // old tags whose freeing is deferred
	int m_rob;
	logic [dispatch_pkg::ROB_W-1:0] m_tail;
	dispatch_pkg::disp_state_t m_state;

	// packet expected on the next cycle
	logic x_valid, x_ill, x_s1r, x_s2r, x_halt;
	logic [3:0] x_op;
	logic [1:0] x_fu, x_opa;
	logic [2:0] x_opb;
	tag_t x_dest, x_old, x_s1, x_s2;
	logic [dispatch_pkg::ROB_W-1:0] x_rob;
	logic [31:0] x_pc;

	logic [31:0] lcg_state = 32'h60c0_528f;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int n_issued = 0;
	int halt_cycles = 0;
	bit have_inst = 0;
	bit wfi_sent = 0;

	rename_dispatch u_dut (
		.clock         (clock),
		.rst_n         (rst_n),
		.inst_valid    (inst_valid),
		.inst          (inst),
		.pc            (pc),
		.rs_stall      (rs_stall),
		.cdb_valid     (cdb_valid),
		.cdb_pr        (cdb_pr),
		.retire_valid  (retire_valid),
		.retire_old_pr (retire_old_pr),
		.stall         (stall),
		.disp_valid    (disp_valid),
		.fu_sel        (fu_sel),
		.op_sel        (op_sel),
		.opa_sel       (opa_sel),
		.opb_sel       (opb_sel),
		.dest_pr       (dest_pr),
		.old_pr        (old_pr),
		.src1_pr       (src1_pr),
		.src1_ready    (src1_ready),
		.src2_pr       (src2_pr),
		.src2_ready    (src2_ready),
		.rob_index     (rob_index),
		.disp_pc       (disp_pc),
		.disp_halt     (disp_halt),
		.illegal       (illegal),
		.halted        (halted)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	function logic [31:0] rand_word();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function int rand_below(int n);
		return int'(rand_word() >> 8) % n; // low bits of an lcg are weak
	endfunction

	function automatic bit is_pending(tag_t t);
		foreach (pend_q[i])
			if (pend_q[i] == t)
				return 1'b1;
		return 1'b0;
	endfunction

	task automatic compare_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("** Error %s: expected %0h, actual %0h at %0t", name, expected, actual,
				$time);
		end
	endtask

	// builds a random instruction and the decode the ISA calls for
	task automatic make_inst(input bit want_wfi);
		dispatch_pkg::inst_t w;
		logic [4:0] rd, rs1, rs2;
		logic [2:0] f3;
		int kind;
		int pick;
		dispatch_pkg::br_op_t   br_ops [6];
		dispatch_pkg::ls_op_t   ld_ops [5];
		dispatch_pkg::alu_op_t  alu_ops [8];
		dispatch_pkg::mult_op_t mul_ops [4];
		// operations listed in funct3 order
		br_ops  = '{dispatch_pkg::BR_BEQ, dispatch_pkg::BR_BNE, dispatch_pkg::BR_BLT,
			dispatch_pkg::BR_BGE, dispatch_pkg::BR_BLTU, dispatch_pkg::BR_BGEU};
		ld_ops  = '{dispatch_pkg::LS_LB, dispatch_pkg::LS_LH, dispatch_pkg::LS_LW,
			dispatch_pkg::LS_LBU, dispatch_pkg::LS_LHU};
		alu_ops = '{dispatch_pkg::ALU_ADD, dispatch_pkg::ALU_SLL, dispatch_pkg::ALU_SLT,
			dispatch_pkg::ALU_SLTU, dispatch_pkg::ALU_XOR, dispatch_pkg::ALU_SRL,
			dispatch_pkg::ALU_OR, dispatch_pkg::ALU_AND};
		mul_ops = '{dispatch_pkg::MULT_MUL, dispatch_pkg::MULT_MULH,
			dispatch_pkg::MULT_MULHSU, dispatch_pkg::MULT_MULHU};
		w      = dispatch_pkg::inst_t'(rand_word()); // immediates stay random
		rd     = (rand_below(8) == 0) ? 5'd0 : 5'(rand_below(32));
		rs1    = 5'(rand_below(32));
		rs2    = 5'(rand_below(32));
		e_fu   = dispatch_pkg::FU_ALU;
		e_op   = 4'(dispatch_pkg::ALU_ADD);
		e_opa  = dispatch_pkg::OPA_IS_RS1;
		e_opb  = dispatch_pkg::OPB_IS_RS2;
		e_dest = 5'd0;
		e_r1   = 5'd0;
		e_r2   = 5'd0;
		e_halt = 1'b0;
		e_ill  = 1'b0;
		kind   = want_wfi ? 99 : rand_below(16);
		case (kind)
			0, 1: begin // lui, auipc
				w.u.opcode = (kind == 0) ? dispatch_pkg::OPC_LUI : dispatch_pkg::OPC_AUIPC;
				w.u.rd     = rd;
				e_opa      = (kind == 0) ? dispatch_pkg::OPA_IS_ZERO : dispatch_pkg::OPA_IS_PC;
				e_opb      = dispatch_pkg::OPB_IS_U_IMM;
				e_dest     = rd;
			end
			2: begin
				w.j.opcode = dispatch_pkg::OPC_JAL;
				w.j.rd     = rd;
				e_fu       = dispatch_pkg::FU_BRANCH;
				e_op       = 4'(dispatch_pkg::BR_UNCOND);
				e_opa      = dispatch_pkg::OPA_IS_PC;
				e_opb      = dispatch_pkg::OPB_IS_J_IMM;
				e_dest     = rd;
			end
			3: begin
				w.i.opcode = dispatch_pkg::OPC_JALR;
				w.i.funct3 = 3'd0;
				w.i.rd     = rd;
				w.i.rs1    = rs1;
				e_fu       = dispatch_pkg::FU_BRANCH;
				e_op       = 4'(dispatch_pkg::BR_UNCOND);
				e_opb      = dispatch_pkg::OPB_IS_I_IMM;
				e_dest     = rd;
				e_r1       = rs1;
			end
			4, 5: begin
				pick       = rand_below(6);
				f3         = (pick < 2) ? 3'(pick) : 3'(pick + 2); // skip 2 and 3
				w.b.opcode = dispatch_pkg::OPC_BRANCH;
				w.b.funct3 = f3;
				w.b.rs1    = rs1;
				w.b.rs2    = rs2;
				e_fu       = dispatch_pkg::FU_BRANCH;
				e_op       = 4'(br_ops[pick]);
				e_opa      = dispatch_pkg::OPA_IS_PC;
				e_opb      = dispatch_pkg::OPB_IS_B_IMM;
				e_r1       = rs1;
				e_r2       = rs2;
			end
			6, 7: begin
				pick       = rand_below(5);
				f3         = (pick < 3) ? 3'(pick) : 3'(pick + 1);
				w.i.opcode = dispatch_pkg::OPC_LOAD;
				w.i.funct3 = f3;
				w.i.rd     = rd;
				w.i.rs1    = rs1;
				e_fu       = dispatch_pkg::FU_LS;
				e_op       = 4'(ld_ops[pick]);
				e_opb      = dispatch_pkg::OPB_IS_I_IMM;
				e_dest     = rd;
				e_r1       = rs1;
			end
			8, 9: begin
				f3         = 3'(rand_below(3));
				w.s.opcode = dispatch_pkg::OPC_STORE;
				w.s.funct3 = f3;
				w.s.rs1    = rs1;
				w.s.rs2    = rs2;
				e_op       = 4'(dispatch_pkg::ALU_SB) + f3; // sb, sh, sw
				e_opb      = dispatch_pkg::OPB_IS_S_IMM;
				e_r1       = rs1;
				e_r2       = rs2;
			end
			10, 11: begin
				f3         = 3'(rand_below(8));
				pick       = rand_below(2);
				w.i.opcode = dispatch_pkg::OPC_OP_IMM;
				w.i.funct3 = f3;
				w.i.rd     = rd;
				w.i.rs1    = rs1;
				if (f3 == 3'd1 || f3 == 3'd5)
					w.r.funct7 = (f3 == 3'd5 && pick == 1) ? 7'b0100000 : 7'b0000000;
				e_op   = (f3 == 3'd5 && pick == 1) ? 4'(dispatch_pkg::ALU_SRA) :
					4'(alu_ops[f3]);
				e_opb  = dispatch_pkg::OPB_IS_I_IMM;
				e_dest = rd;
				e_r1   = rs1;
			end
			12, 13, 14: begin // op with kind 14 as the multiplies
				pick     = rand_below(10);
				f3       = (pick == 8) ? 3'd0 : (pick == 9) ? 3'd5 : 3'(pick);
				w.r      = '{funct7: (pick >= 8) ? 7'b0100000 : 7'b0000000, rs2: rs2, rs1: rs1,
					funct3: f3, rd: rd, opcode: dispatch_pkg::OPC_OP};
				e_op     = (pick == 8) ? 4'(dispatch_pkg::ALU_SUB) :
					(pick == 9) ? 4'(dispatch_pkg::ALU_SRA) : 4'(alu_ops[f3]);
				if (kind == 14) begin
					w.r.funct7 = 7'b0000001;
					w.r.funct3 = 3'(rand_below(4));
					e_fu       = dispatch_pkg::FU_MULT;
					e_op       = 4'(mul_ops[w.r.funct3[1:0]]); // mul, mulh, mulhsu, mulhu
				end
				e_dest = rd;
				e_r1   = rs1;
				e_r2   = rs2;
			end
			15: begin
				pick = rand_below(4);
				if (pick == 0)
					w.r.opcode = 7'b0001011; // custom-0
				else if (pick == 1)
					w = 32'h0000_0073; // ecall
				else if (pick == 2)
					w.r = '{7'b0000001, rs2, rs1, 3'(4 + rand_below(4)), rd,
						dispatch_pkg::OPC_OP}; // div and rem
				else
					w.r.opcode = 7'b1111111;
				e_ill = 1'b1;
			end
			default: begin
				w      = 32'h1050_0073; // wfi
				e_halt = 1'b1;
			end
		endcase
		inst = w;
	endtask

	task automatic run_cycle();
		tag_t tag;
		logic exp_stall, acc, legal;
		@(negedge clock);
		// outputs registered at the last edge
		compare_value("disp_valid", x_valid, disp_valid);
		compare_value("illegal", x_ill, illegal);
		compare_value("halted", m_state == dispatch_pkg::HALTED, halted);
		if (x_valid) begin
			compare_value("fu_sel", x_fu, fu_sel);
			compare_value("op_sel", x_op, op_sel);
			compare_value("opa_sel", x_opa, opa_sel);
			compare_value("opb_sel", x_opb, opb_sel);
			compare_value("dest_pr", x_dest, dest_pr);
			compare_value("old_pr", x_old, old_pr);
			compare_value("src1_pr", x_s1, src1_pr);
			compare_value("src1_ready", x_s1r, src1_ready);
			compare_value("src2_pr", x_s2, src2_pr);
			compare_value("src2_ready", x_s2r, src2_ready);
			compare_value("rob_index", x_rob, rob_index);
			compare_value("disp_pc", x_pc, disp_pc);
			compare_value("disp_halt", x_halt, disp_halt);
		end
		if (!have_inst) begin
			make_inst(!wfi_sent && n_issued == NUM_INST - 1);
			pc        = pc + 32'd4;
			have_inst = 1'b1;
		end
		inst_valid = (rand_below(8) != 0);
		rs_stall   = (rand_below(4) == 0);

		// writeback sometimes aimed at a source being looked up right now
		cdb_valid = 1'b0;
		if (e_r1 != 5'd0 && is_pending(m_map[e_r1]) && rand_below(4) == 0) begin
			cdb_valid = 1'b1;
			cdb_pr    = m_map[e_r1];
		end else if (pend_q.size() > 0 && rand_below(4) != 0) begin
			cdb_valid = 1'b1;
			cdb_pr    = pend_q[rand_below(pend_q.size())];
		end
		if (cdb_valid)
			foreach (pend_q[i])
				if (pend_q[i] == cdb_pr) begin
					pend_q.delete(i);
					break;
				end

		// retire in program order once the head has written back
		retire_valid  = 1'b0;
		retire_old_pr = '0;
		if (rob_dest_q.size() > 0 && !is_pending(rob_dest_q[0]) && rand_below(4) != 0) begin
			tag = rob_old_q.pop_front();
			void'(rob_dest_q.pop_front());
			// hold back freed tags early on to run the free list dry
			if (tag != '0 && n_issued < NUM_INST / 2 && fl_q.size() > 0 &&
					rand_below(4) != 0) begin
				held_q.push_back(tag);
				tag = '0;
			end else if (tag == '0 && held_q.size() > 0) begin
				tag = held_q.pop_front();
			end
			retire_valid  = 1'b1;
			retire_old_pr = tag;
		end

		#1;
		exp_stall = rs_stall || m_rob == dispatch_pkg::ROB_DEPTH ||
			(e_dest != 5'd0 && fl_q.size() == 0) || m_state != dispatch_pkg::RUN;
		compare_value("stall", exp_stall, stall);
		acc     = inst_valid && !exp_stall;
		legal   = acc && !e_ill;
		x_valid = legal;
		x_ill   = acc && e_ill;
		if (legal) begin
			x_fu   = e_fu;
			x_op   = e_op;
			x_opa  = e_opa;
			x_opb  = e_opb;
			x_dest = (e_dest != 5'd0) ? fl_q[0] : '0;
			x_old  = m_map[e_dest];
			x_s1   = m_map[e_r1];
			x_s1r  = m_rdy[e_r1] || (cdb_valid && cdb_pr == m_map[e_r1]);
			x_s2   = m_map[e_r2];
			x_s2r  = m_rdy[e_r2] || (cdb_valid && cdb_pr == m_map[e_r2]);
			x_rob  = m_tail;
			x_pc   = pc;
			x_halt = e_halt;
		end

		// model update mirrors the coming edge
		if (cdb_valid)
			for (int i = 0; i < 32; i++)
				if (m_map[i] == cdb_pr)
					m_rdy[i] = 1'b1;
		if (legal) begin
			rob_dest_q.push_back(x_dest);
			rob_old_q.push_back(x_old);
			m_tail = m_tail + 1'b1;
			if (e_dest != 5'd0) begin
				tag = fl_q.pop_front();
				m_map[e_dest] = tag;
				m_rdy[e_dest] = 1'b0;
				pend_q.push_back(tag);
			end
			if (e_halt)
				wfi_sent = 1'b1;
		end
		if (retire_valid && retire_old_pr != '0)
			fl_q.push_back(retire_old_pr);
		if (m_state == dispatch_pkg::RUN && legal && e_halt)
			m_state = dispatch_pkg::DRAIN;
		else if (m_state == dispatch_pkg::DRAIN && m_rob == 0)
			m_state = dispatch_pkg::HALTED;
		m_rob = m_rob + int'(legal) - int'(retire_valid);
		if (acc) begin
			n_issued++;
			have_inst = 1'b0;
		end
	endtask

	always @(posedge clock) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("timeout: the unit did not halt within %0d cycles", CYCLE_LIMIT);
			$display("checks: %0d, errors: %0d", checks, errors);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	initial begin
		rst_n         = 1'b0;
		inst_valid    = 1'b0;
		inst          = '0;
		pc            = 32'h0000_1000;
		rs_stall      = 1'b0;
		cdb_valid     = 1'b0;
		cdb_pr        = '0;
		retire_valid  = 1'b0;
		retire_old_pr = '0;
		x_valid       = 1'b0;
		x_ill         = 1'b0;
		for (int i = 0; i < 32; i++) begin
			m_map[i] = tag_t'(i); // identity after reset
			m_rdy[i] = 1'b1;
		end
		for (int i = 32; i < dispatch_pkg::NUM_PR; i++)
			fl_q.push_back(tag_t'(i));
		m_rob   = 0;
		m_tail  = '0;
		m_state = dispatch_pkg::RUN;
		repeat (2) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;
		while (halt_cycles < 8) begin
			run_cycle();
			if (m_state == dispatch_pkg::HALTED)
				halt_cycles++;
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: rtl/rename_dispatch.sv
`timescale 1ns/1ns
module rename_dispatch (
	input  logic                           clock,
	input  logic                           rst_n,
	input  logic                           inst_valid,
	input  logic [31:0]                    inst,
	input  logic [31:0]                    pc,
	input  logic                           rs_stall,
	input  logic                           cdb_valid,
	input  logic [dispatch_pkg::PR_W-1:0]  cdb_pr,
	input  logic                           retire_valid,
	input  logic [dispatch_pkg::PR_W-1:0]  retire_old_pr,
	output logic                           stall,
	output logic                           disp_valid,
	output dispatch_pkg::fu_sel_t          fu_sel,
	output dispatch_pkg::op_sel_t          op_sel,
	output dispatch_pkg::opa_sel_t         opa_sel,
	output dispatch_pkg::opb_sel_t         opb_sel,
	output logic [dispatch_pkg::PR_W-1:0]  dest_pr,
	output logic [dispatch_pkg::PR_W-1:0]  old_pr,
	output logic [dispatch_pkg::PR_W-1:0]  src1_pr,
	output logic                           src1_ready,
	output logic [dispatch_pkg::PR_W-1:0]  src2_pr,
	output logic                           src2_ready,
	output logic [dispatch_pkg::ROB_W-1:0] rob_index,
	output logic [31:0]                    disp_pc,
	output logic                           disp_halt,
	output logic                           illegal,
	output logic                           halted
);

	dispatch_pkg::fu_sel_t  dec_fu;
	dispatch_pkg::op_sel_t  dec_op;
	dispatch_pkg::opa_sel_t dec_opa;
	dispatch_pkg::opb_sel_t dec_opb;
	logic [4:0] dec_dest, dec_reg1, dec_reg2;
	logic dec_halt, dec_illegal;

	logic [dispatch_pkg::PR_W-1:0] map_pr1, map_pr2, map_old, fl_head;
	logic map_rdy1, map_rdy2, fl_empty;
	logic [dispatch_pkg::ROB_W-1:0] rob_tail;
	logic rob_full, rob_empty, running;
	logic need_pr, accept, legal;

	inst_decoder u_decoder (
		.inst       (inst),
		.fu_sel     (dec_fu),
		.op_sel     (dec_op),
		.opa_sel    (dec_opa),
		.opb_sel    (dec_opb),
		.dest_reg   (dec_dest),
		.reg1       (dec_reg1),
		.reg2       (dec_reg2),
		.is_halt    (dec_halt),
		.is_illegal (dec_illegal)
	);

	assign need_pr = (dec_dest != dispatch_pkg::ZERO_REG);

	// structural hazards hold the instruction in fetch
	assign stall  = rs_stall | rob_full | (need_pr & fl_empty) | ~running;
	assign accept = inst_valid & ~stall;
	assign legal  = accept & ~dec_illegal; // illegal words consume nothing

	map_table u_map_table (
		.clock     (clock),
		.rst_n     (rst_n),
		.rd1_ar    (dec_reg1),
		.rd2_ar    (dec_reg2),
		.wr_en     (legal & need_pr),
		.wr_ar     (dec_dest),
		.wr_pr     (fl_head),
		.wake_en   (cdb_valid),
		.wake_pr   (cdb_pr),
		.rd1_pr    (map_pr1),
		.rd1_ready (map_rdy1),
		.rd2_pr    (map_pr2),
		.rd2_ready (map_rdy2),
		.old_pr    (map_old)
	);

	free_list u_free_list (
		.clock   (clock),
		.rst_n   (rst_n),
		.pop     (legal & need_pr),
		.push    (retire_valid && (retire_old_pr != dispatch_pkg::ZERO_REG)),
		.push_pr (retire_old_pr),
		.head_pr (fl_head),
		.empty   (fl_empty)
	);

	rob_tracker u_rob_tracker (
		.clock      (clock),
		.rst_n      (rst_n),
		.alloc      (legal), // wfi takes a slot too
		.retire     (retire_valid),
		.tail_index (rob_tail),
		.full       (rob_full),
		.empty      (rob_empty)
	);

	dispatch_ctrl u_dispatch_ctrl (
		.clock       (clock),
		.rst_n       (rst_n),
		.accept_halt (legal & dec_halt),
		.rob_empty   (rob_empty),
		.running     (running),
		.halted      (halted)
	);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			disp_valid <= 1'b0;
			illegal    <= 1'b0;
		end else begin
			disp_valid <= legal;
			illegal    <= accept & dec_illegal;
		end
	end

	// packet payload, only meaningful with disp_valid
	always_ff @(posedge clock) begin
		if (legal) begin
			fu_sel     <= dec_fu;
			op_sel     <= dec_op;
			opa_sel    <= dec_opa;
			opb_sel    <= dec_opb;
			dest_pr    <= need_pr ? fl_head : '0; // x0 stays on p0
			old_pr     <= map_old;
			src1_pr    <= map_pr1;
			src1_ready <= map_rdy1;
			src2_pr    <= map_pr2;
			src2_ready <= map_rdy2;
			rob_index  <= rob_tail;
			disp_pc    <= pc;
			disp_halt  <= dec_halt;
		end
	end

endmodule

// File: rtl/dispatch_ctrl.sv
`timescale 1ns/1ns
module dispatch_ctrl (
	input  logic clock,
	input  logic rst_n,
	input  logic accept_halt,
	input  logic rob_empty,
	output logic running,
	output logic halted
);

	dispatch_pkg::disp_state_t state;
	dispatch_pkg::disp_state_t state_next;

	always_comb begin
		state_next = state;
		case (state)
			dispatch_pkg::RUN: begin
				if (accept_halt)
					state_next = dispatch_pkg::DRAIN;
			end
			// the wfi holds a ROB slot, so empty means it has retired
			dispatch_pkg::DRAIN: begin
				if (rob_empty)
					state_next = dispatch_pkg::HALTED;
			end
			default: state_next = dispatch_pkg::HALTED; // only reset leaves
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rst_n)
			state <= dispatch_pkg::RUN;
		else
			state <= state_next;
	end

	assign running = (state == dispatch_pkg::RUN);
	assign halted  = (state == dispatch_pkg::HALTED);

endmodule

// File: rtl/rob_tracker.sv
`timescale 1ns/1ns
module rob_tracker (
	input  logic                           clock,
	input  logic                           rst_n,
	input  logic                           alloc,
	input  logic                           retire,
	output logic [dispatch_pkg::ROB_W-1:0] tail_index,
	output logic                           full,
	output logic                           empty
);

	logic [dispatch_pkg::ROB_W:0] count; // in-flight entries

	assign full  = (count == dispatch_pkg::ROB_DEPTH);
	assign empty = (count == '0);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			tail_index <= '0;
			count      <= '0;
		end else begin
			if (alloc)
				tail_index <= tail_index + 1'b1; // wraps at ROB_DEPTH
			count <= count + alloc - retire;
		end
	end

endmodule

// File: rtl/free_list.sv
`timescale 1ns/1ns
module free_list (
	input  logic                          clock,
	input  logic                          rst_n,
	input  logic                          pop,
	input  logic                          push,
	input  logic [dispatch_pkg::PR_W-1:0] push_pr,
	output logic [dispatch_pkg::PR_W-1:0] head_pr,
	output logic                          empty
);

	logic [dispatch_pkg::PR_W-1:0] slots [dispatch_pkg::FL_DEPTH];
	logic [dispatch_pkg::FL_W-1:0] head;
	logic [dispatch_pkg::FL_W-1:0] tail;
	logic [dispatch_pkg::FL_W:0]   count; // one extra bit to hold a full list

	assign head_pr = slots[head];
	assign empty   = (count == '0);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			head  <= '0;
			tail  <= '0; // wraps onto head when full
			count <= (dispatch_pkg::FL_W + 1)'(dispatch_pkg::FL_DEPTH);
			// tags above the architectural ones start out free
			for (int i = 0; i < dispatch_pkg::FL_DEPTH; i++)
				slots[i] <= dispatch_pkg::PR_W'(dispatch_pkg::ARCH_REGS + i);
		end else begin
			if (push) begin
				slots[tail] <= push_pr;
				tail        <= tail + 1'b1;
			end
			if (pop)
				head <= head + 1'b1;
			count <= count + push - pop; // both at once leaves it alone
		end
	end

endmodule

// File: rtl/map_table.sv
`timescale 1ns/1ns
module map_table (
	input  logic                          clock,
	input  logic                          rst_n,
	input  logic [4:0]                    rd1_ar,
	input  logic [4:0]                    rd2_ar,
	input  logic                          wr_en,
	input  logic [4:0]                    wr_ar,
	input  logic [dispatch_pkg::PR_W-1:0] wr_pr,
	input  logic                          wake_en,
	input  logic [dispatch_pkg::PR_W-1:0] wake_pr,
	output logic [dispatch_pkg::PR_W-1:0] rd1_pr,
	output logic                          rd1_ready,
	output logic [dispatch_pkg::PR_W-1:0] rd2_pr,
	output logic                          rd2_ready,
	output logic [dispatch_pkg::PR_W-1:0] old_pr
);

	logic [dispatch_pkg::PR_W-1:0] tag_map [dispatch_pkg::ARCH_REGS];
	logic [dispatch_pkg::ARCH_REGS-1:0] ready;

	assign rd1_pr = tag_map[rd1_ar];
	assign rd2_pr = tag_map[rd2_ar];

	// same-cycle writeback counts as ready
	assign rd1_ready = ready[rd1_ar] | (wake_en && (wake_pr == tag_map[rd1_ar]));
	assign rd2_ready = ready[rd2_ar] | (wake_en && (wake_pr == tag_map[rd2_ar]));

	assign old_pr = tag_map[wr_ar]; // goes to the ROB, freed at retire

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < dispatch_pkg::ARCH_REGS; i++) begin
				tag_map[i] <= dispatch_pkg::PR_W'(i); // identity map
				ready[i]   <= 1'b1;
			end
		end else begin
			if (wake_en) begin
				for (int i = 0; i < dispatch_pkg::ARCH_REGS; i++) begin
					if (tag_map[i] == wake_pr)
						ready[i] <= 1'b1;
				end
			end
			// new producer wins over a wakeup of the old tag
			if (wr_en) begin
				tag_map[wr_ar] <= wr_pr;
				ready[wr_ar]   <= 1'b0;
			end
		end
	end

endmodule

// File: rtl/inst_decoder.sv
`timescale 1ns/1ns
module inst_decoder (
	input  dispatch_pkg::inst_t    inst,
	output dispatch_pkg::fu_sel_t  fu_sel,
	output dispatch_pkg::op_sel_t  op_sel,
	output dispatch_pkg::opa_sel_t opa_sel,
	output dispatch_pkg::opb_sel_t opb_sel,
	output logic [4:0]             dest_reg,
	output logic [4:0]             reg1,
	output logic [4:0]             reg2,
	output logic                   is_halt,
	output logic                   is_illegal
);

	always_comb begin
		// defaults behave like a nop with no registers touched
		fu_sel     = dispatch_pkg::FU_ALU;
		op_sel     = '0;
		opa_sel    = dispatch_pkg::OPA_IS_RS1;
		opb_sel    = dispatch_pkg::OPB_IS_RS2;
		dest_reg   = dispatch_pkg::ZERO_REG;
		reg1       = dispatch_pkg::ZERO_REG;
		reg2       = dispatch_pkg::ZERO_REG;
		is_halt    = 1'b0;
		is_illegal = 1'b0;

		casez ({inst.r.funct7, inst.r.funct3, inst.r.opcode})
			{7'b???????, 3'b???, dispatch_pkg::OPC_LUI}: begin
				op_sel.alu = dispatch_pkg::ALU_ADD;
				dest_reg   = inst.u.rd;
				opa_sel    = dispatch_pkg::OPA_IS_ZERO; // 0 + imm
				opb_sel    = dispatch_pkg::OPB_IS_U_IMM;
			end
			{7'b???????, 3'b???, dispatch_pkg::OPC_AUIPC}: begin
				op_sel.alu = dispatch_pkg::ALU_ADD;
				dest_reg   = inst.u.rd;
				opa_sel    = dispatch_pkg::OPA_IS_PC;
				opb_sel    = dispatch_pkg::OPB_IS_U_IMM;
			end
			{7'b???????, 3'b???, dispatch_pkg::OPC_JAL}: begin
				fu_sel    = dispatch_pkg::FU_BRANCH;
				op_sel.br = dispatch_pkg::BR_UNCOND;
				dest_reg  = inst.j.rd;
				opa_sel   = dispatch_pkg::OPA_IS_PC;
				opb_sel   = dispatch_pkg::OPB_IS_J_IMM;
			end
			{7'b???????, 3'b000, dispatch_pkg::OPC_JALR}: begin
				fu_sel    = dispatch_pkg::FU_BRANCH;
				op_sel.br = dispatch_pkg::BR_UNCOND;
				dest_reg  = inst.i.rd;
				reg1      = inst.i.rs1;
				opb_sel   = dispatch_pkg::OPB_IS_I_IMM;
			end
			{7'b???????, 3'b00?, dispatch_pkg::OPC_BRANCH},
			{7'b???????, 3'b1??, dispatch_pkg::OPC_BRANCH}: begin
				fu_sel    = dispatch_pkg::FU_BRANCH;
				op_sel.br = dispatch_pkg::br_op_t'({1'b0, inst.b.funct3});
				reg1      = inst.b.rs1;
				reg2      = inst.b.rs2;
				opa_sel   = dispatch_pkg::OPA_IS_PC; // target = pc + imm
				opb_sel   = dispatch_pkg::OPB_IS_B_IMM;
			end
			{7'b???????, 3'b00?, dispatch_pkg::OPC_LOAD},
			{7'b???????, 3'b010, dispatch_pkg::OPC_LOAD},
			{7'b???????, 3'b10?, dispatch_pkg::OPC_LOAD}: begin
				fu_sel    = dispatch_pkg::FU_LS;
				op_sel.ls = dispatch_pkg::ls_op_t'({1'b0, inst.i.funct3});
				dest_reg  = inst.i.rd;
				reg1      = inst.i.rs1;
				opb_sel   = dispatch_pkg::OPB_IS_I_IMM;
			end
			// stores go to the ALU for address generation
			{7'b???????, 3'b00?, dispatch_pkg::OPC_STORE},
			{7'b???????, 3'b010, dispatch_pkg::OPC_STORE}: begin
				op_sel.alu = dispatch_pkg::alu_op_t'({2'b11, inst.s.funct3[1:0]});
				reg1       = inst.s.rs1;
				reg2       = inst.s.rs2;
				opb_sel    = dispatch_pkg::OPB_IS_S_IMM;
			end
			{7'b???????, 3'b?1?, dispatch_pkg::OPC_OP_IMM},
			{7'b???????, 3'b?00, dispatch_pkg::OPC_OP_IMM},
			{7'b0000000, 3'b?01, dispatch_pkg::OPC_OP_IMM}: begin
				op_sel.alu = dispatch_pkg::alu_op_t'({1'b0, inst.i.funct3});
				dest_reg   = inst.i.rd;
				reg1       = inst.i.rs1;
				opb_sel    = dispatch_pkg::OPB_IS_I_IMM;
			end
			{7'b0100000, 3'b101, dispatch_pkg::OPC_OP_IMM}: begin
				op_sel.alu = dispatch_pkg::ALU_SRA; // srai
				dest_reg   = inst.i.rd;
				reg1       = inst.i.rs1;
				opb_sel    = dispatch_pkg::OPB_IS_I_IMM;
			end
			{7'b0000000, 3'b???, dispatch_pkg::OPC_OP}: begin
				op_sel.alu = dispatch_pkg::alu_op_t'({1'b0, inst.r.funct3});
				dest_reg   = inst.r.rd;
				reg1       = inst.r.rs1;
				reg2       = inst.r.rs2;
			end
			{7'b0100000, 3'b000, dispatch_pkg::OPC_OP},
			{7'b0100000, 3'b101, dispatch_pkg::OPC_OP}: begin
				op_sel.alu = inst.r.funct3[2] ? dispatch_pkg::ALU_SRA : dispatch_pkg::ALU_SUB;
				dest_reg   = inst.r.rd;
				reg1       = inst.r.rs1;
				reg2       = inst.r.rs2;
			end
			// M extension, multiplies only
			{7'b0000001, 3'b0??, dispatch_pkg::OPC_OP}: begin
				fu_sel      = dispatch_pkg::FU_MULT;
				op_sel.mult = dispatch_pkg::mult_op_t'({2'b00, inst.r.funct3[1:0]});
				dest_reg    = inst.r.rd;
				reg1        = inst.r.rs1;
				reg2        = inst.r.rs2;
			end
			{7'b???????, 3'b000, dispatch_pkg::OPC_SYSTEM}: begin
				if (inst == dispatch_pkg::WFI_INST)
					is_halt = 1'b1;
				else
					is_illegal = 1'b1; // ecall, ebreak and friends
			end
			default: is_illegal = 1'b1;
		endcase
	end

endmodule

// File: rtl/dispatch_pkg.sv
package dispatch_pkg;

	localparam int NUM_PR    = 64;
	localparam int PR_W      = $clog2(NUM_PR);
	localparam int ARCH_REGS = 32;
	localparam int FL_DEPTH  = NUM_PR - ARCH_REGS; // tags not mapped after reset
	localparam int FL_W      = $clog2(FL_DEPTH);
	localparam int ROB_DEPTH = 16;
	localparam int ROB_W     = $clog2(ROB_DEPTH);

	localparam logic [4:0] ZERO_REG = 5'd0; // x0 and p0, never renamed

	// major opcodes
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	localparam logic [31:0] WFI_INST = 32'h1050_0073;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo; // sits where rd would be
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} inst_t;

	typedef enum logic [1:0] {FU_ALU, FU_BRANCH, FU_LS, FU_MULT} fu_sel_t;

	// low codes line up with funct3 of OP/OP-IMM
	typedef enum logic [3:0] {
		ALU_ADD  = 4'h0,
		ALU_SLL  = 4'h1,
		ALU_SLT  = 4'h2,
		ALU_SLTU = 4'h3,
		ALU_XOR  = 4'h4,
		ALU_SRL  = 4'h5,
		ALU_OR   = 4'h6,
		ALU_AND  = 4'h7,
		ALU_SUB  = 4'h8,
		ALU_SRA  = 4'h9,
		ALU_SB   = 4'hc, // stores keep funct3 in bits 1:0
		ALU_SH   = 4'hd,
		ALU_SW   = 4'he
	} alu_op_t;

	// conditional codes equal branch funct3
	typedef enum logic [3:0] {
		BR_BEQ    = 4'h0,
		BR_BNE    = 4'h1,
		BR_UNCOND = 4'h2,
		BR_BLT    = 4'h4,
		BR_BGE    = 4'h5,
		BR_BLTU   = 4'h6,
		BR_BGEU   = 4'h7
	} br_op_t;

	typedef enum logic [3:0] {
		LS_LB  = 4'h0,
		LS_LH  = 4'h1,
		LS_LW  = 4'h2,
		LS_LBU = 4'h4,
		LS_LHU = 4'h5
	} ls_op_t;

	typedef enum logic [3:0] {MULT_MUL, MULT_MULH, MULT_MULHSU, MULT_MULHU} mult_op_t;

	// fu_sel_t picks the member that means something
	typedef union packed {
		alu_op_t  alu;
		br_op_t   br;
		ls_op_t   ls;
		mult_op_t mult;
	} op_sel_t;

	typedef enum logic [1:0] {OPA_IS_RS1, OPA_IS_PC, OPA_IS_ZERO} opa_sel_t;

	typedef enum logic [2:0] {
		OPB_IS_RS2,
		OPB_IS_I_IMM,
		OPB_IS_S_IMM,
		OPB_IS_B_IMM,
		OPB_IS_U_IMM,
		OPB_IS_J_IMM
	} opb_sel_t;

	typedef enum logic [1:0] {RUN, DRAIN, HALTED} disp_state_t;

endpackage
